// ==== design/byte_ram.sv ====
//==========================================================================
// Byte RAM
// Single port synchronous memory with registered read data
//==========================================================================
`timescale 1ns/100ps
`include "loader_consts.svh"

module byte_ram (
    input logic       clk_sys_i,
    mem_bus_if.memory bus
);

    logic [7:0] mem [0:(1 << `MEM_AW) - 1];
    logic [7:0] rdata_q;

    always_ff @(posedge clk_sys_i) begin
        if (bus.req) begin
            if (bus.we)
                mem[bus.addr] <= bus.wdata;
            else
                rdata_q <= mem[bus.addr];
        end
    end

    assign bus.rdata = rdata_q;

endmodule

// ==== design/loader_consts.svh ====
//==========================================================================
// Loader constants
// Widths, download indices, tape and PRG base addresses, and the
// zero page BASIC pointer locations patched after a PRG load
//==========================================================================
`ifndef LOADER_CONSTS_SVH
`define LOADER_CONSTS_SVH

`define MEM_AW            18
`define TAP_MEM_START     18'h20000
`define PRG_DEFAULT_ADDR  16'hA000

// Download indices from the host
`define IDX_PRG_A         8'h01
`define IDX_PRG_B         8'h41
`define IDX_TAP           8'h81

`define TAP_VERSION_OFS   24'd12
`define INJECT_LAST       5'd31

// BASIC pointers, low byte first in each pair
`define PTR_ADDR_0        16'h002D
`define PTR_ADDR_1        16'h002E
`define PTR_ADDR_2        16'h002F
`define PTR_ADDR_3        16'h0030
`define PTR_ADDR_4        16'h0031
`define PTR_ADDR_5        16'h0032
`define PTR_ADDR_6        16'h00AE
`define PTR_ADDR_7        16'h00AF

`endif

// ==== design/loader_pkg.sv ====
//==========================================================================
// Loader types
// Address and data vectors shared by the loader blocks, and the tape
// fetch state machine encoding
//==========================================================================
`include "loader_consts.svh"

package loader_pkg;

    // Byte address into the loader memory
    typedef logic [`MEM_AW-1:0] mem_addr_t;

    // CPU side or PRG load address
    typedef logic [15:0] cpu_addr_t;

    typedef logic [7:0] byte_t;

    // Byte offset inside the current download
    typedef logic [23:0] dl_addr_t;

    typedef logic [4:0] inject_step_t;

    typedef enum logic [1:0] {
        PLAY_IDLE,
        PLAY_READ,
        PLAY_HOLD
    } play_state_t;

endpackage

// ==== design/loader_top.sv ====
//==========================================================================
// Loader top
// PRG and TAP download paths, tape playback and the CPU byte port
// sharing one byte memory
//==========================================================================
`timescale 1ns/100ps

module loader_top (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  dl_active_i,
    input  logic                  dl_wr_i,
    input  logic                  no_load_addr_i,
    input  loader_pkg::byte_t     dl_index_i,
    input  loader_pkg::dl_addr_t  dl_addr_i,
    input  loader_pkg::byte_t     dl_data_i,
    input  logic                  p2_h_i,
    input  logic                  tap_full_i,
    input  logic                  cpu_sel_i,
    input  logic                  cpu_we_i,
    input  loader_pkg::cpu_addr_t cpu_addr_i,
    input  loader_pkg::byte_t     cpu_data_i,
    output loader_pkg::byte_t     cpu_data_o,
    output loader_pkg::byte_t     tap_byte_o,
    output logic                  tap_wrreq_o,
    output logic                  tap_version_o,
    output logic                  tap_restart_o,
    output logic                  force_reset_o
);

    mem_bus_if prg_bus ();
    mem_bus_if tap_bus ();
    mem_bus_if ram_bus ();

    prg_loader u_prg_loader (
        .clk_sys_i      (clk_sys),
        .reset_i        (reset),
        .dl_active_i    (dl_active_i),
        .dl_wr_i        (dl_wr_i),
        .no_load_addr_i (no_load_addr_i),
        .dl_index_i     (dl_index_i),
        .dl_addr_i      (dl_addr_i),
        .dl_data_i      (dl_data_i),
        .force_reset_o  (force_reset_o),
        .bus            (prg_bus)
    );

    tape_streamer u_tape_streamer (
        .clk_sys_i     (clk_sys),
        .reset_i       (reset),
        .dl_active_i   (dl_active_i),
        .dl_wr_i       (dl_wr_i),
        .dl_index_i    (dl_index_i),
        .dl_addr_i     (dl_addr_i),
        .dl_data_i     (dl_data_i),
        .p2_h_i        (p2_h_i),
        .tap_full_i    (tap_full_i),
        .tap_byte_o    (tap_byte_o),
        .tap_wrreq_o   (tap_wrreq_o),
        .tap_version_o (tap_version_o),
        .tap_restart_o (tap_restart_o),
        .bus           (tap_bus)
    );

    mem_arbiter u_mem_arbiter (
        .clk_sys_i  (clk_sys),
        .reset_i    (reset),
        .p2_h_i     (p2_h_i),
        .cpu_sel_i  (cpu_sel_i),
        .cpu_we_i   (cpu_we_i),
        .cpu_addr_i (cpu_addr_i),
        .cpu_data_i (cpu_data_i),
        .cpu_data_o (cpu_data_o),
        .prg_bus    (prg_bus),
        .tap_bus    (tap_bus),
        .ram_bus    (ram_bus)
    );

    byte_ram u_byte_ram (
        .clk_sys_i (clk_sys),
        .bus       (ram_bus)
    );

endmodule

// ==== design/mem_arbiter.sv ====
//==========================================================================
// Memory arbiter
// Fixed priority grant of one requester per cycle, read data routed
// back to the owner of the read
//==========================================================================
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                  clk_sys_i,
    input  logic                  reset_i,
    input  logic                  p2_h_i,
    input  logic                  cpu_sel_i,
    input  logic                  cpu_we_i,
    input  loader_pkg::cpu_addr_t cpu_addr_i,
    input  loader_pkg::byte_t     cpu_data_i,
    output loader_pkg::byte_t     cpu_data_o,
    mem_bus_if.arbiter            prg_bus,
    mem_bus_if.arbiter            tap_bus,
    mem_bus_if.requester          ram_bus
);

    mem_bus_if cpu_bus ();

    logic              gnt_prg;
    logic              gnt_tap_wr;
    logic              gnt_cpu;
    logic              gnt_tap_rd;
    logic              rd_tap_q;
    logic              rd_cpu_q;
    loader_pkg::byte_t cpu_hold_q;

    // CPU owns the high phase
    assign cpu_bus.req   = cpu_sel_i && p2_h_i;
    assign cpu_bus.we    = cpu_we_i;
    assign cpu_bus.addr  = loader_pkg::mem_addr_t'(cpu_addr_i);
    assign cpu_bus.wdata = cpu_data_i;

    assign gnt_prg    = prg_bus.req;
    assign gnt_tap_wr = !gnt_prg && tap_bus.req && tap_bus.we;
    assign gnt_cpu    = !gnt_prg && !gnt_tap_wr && cpu_bus.req;
    assign gnt_tap_rd = !gnt_prg && !gnt_tap_wr && !gnt_cpu &&
                        tap_bus.req && !tap_bus.we && !p2_h_i;

    always_comb begin
        ram_bus.req = gnt_prg || gnt_tap_wr || gnt_cpu || gnt_tap_rd;
        if (gnt_prg) begin
            ram_bus.we    = prg_bus.we;
            ram_bus.addr  = prg_bus.addr;
            ram_bus.wdata = prg_bus.wdata;
        end else if (gnt_cpu) begin
            ram_bus.we    = cpu_bus.we;
            ram_bus.addr  = cpu_bus.addr;
            ram_bus.wdata = cpu_bus.wdata;
        end else begin
            ram_bus.we    = tap_bus.we;
            ram_bus.addr  = tap_bus.addr;
            ram_bus.wdata = tap_bus.wdata;
        end
    end

    // Owner of the read that returns next cycle
    always_ff @(posedge clk_sys_i) begin
        if (reset_i) begin
            rd_tap_q <= 1'b0;
            rd_cpu_q <= 1'b0;
        end else begin
            rd_tap_q <= gnt_tap_rd;
            rd_cpu_q <= gnt_cpu && !cpu_bus.we;
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (rd_cpu_q)
            cpu_hold_q <= ram_bus.rdata;
    end

    // PRG loader only writes
    assign prg_bus.rdata = '0;
    assign tap_bus.rdata = rd_tap_q ? ram_bus.rdata : '0;
    assign cpu_bus.rdata = rd_cpu_q ? ram_bus.rdata : cpu_hold_q;
    assign cpu_data_o    = cpu_bus.rdata;

    // Downloads are exclusive, so the two loaders never meet here
    a_no_dl_overlap: assert property (
        @(posedge clk_sys_i) disable iff (reset_i)
        !(prg_bus.req && tap_bus.req));

endmodule

// ==== design/mem_bus_if.sv ====
//==========================================================================
// Byte memory bus
// One-cycle request level with write enable, address and data; read
// data returns one cycle after an accepted read
//==========================================================================
`timescale 1ns/100ps

interface mem_bus_if;

    logic                  req;
    logic                  we;
    loader_pkg::mem_addr_t addr;
    loader_pkg::byte_t     wdata;
    loader_pkg::byte_t     rdata;

    // Block that issues requests
    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    // Arbiter side of a requester
    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

    modport memory (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// ==== design/prg_loader.sv ====
//==========================================================================
// PRG loader
// Writes PRG download bytes at their load address, patches the BASIC
// pointers when the download ends and fires the auto reset for $A000
//==========================================================================
`timescale 1ns/100ps
`include "loader_consts.svh"

module prg_loader (
    input  logic                 clk_sys_i,
    input  logic                 reset_i,
    input  logic                 dl_active_i,
    input  logic                 dl_wr_i,
    input  logic                 no_load_addr_i,
    input  loader_pkg::byte_t    dl_index_i,
    input  loader_pkg::dl_addr_t dl_addr_i,
    input  loader_pkg::byte_t    dl_data_i,
    output logic                 force_reset_o,
    mem_bus_if.requester         bus
);

    logic                     prg_dl;
    logic                     prg_dl_d;
    logic                     hdr_byte;
    logic                     inject_wr;
    logic                     auto_reset;
    logic                     req_q;
    loader_pkg::cpu_addr_t    prg_addr;
    loader_pkg::cpu_addr_t    addr_next;
    loader_pkg::cpu_addr_t    ptr_addr;
    loader_pkg::cpu_addr_t    addr_q;
    loader_pkg::byte_t        wdata_q;
    loader_pkg::inject_step_t inject_step;

    assign prg_dl = dl_active_i &&
                    (dl_index_i == `IDX_PRG_A || dl_index_i == `IDX_PRG_B);

    // Odd steps 1 to 15 write one pointer byte each
    assign inject_wr = inject_step[0] && !inject_step[4];

    //==========================================================================
    // Load address tracking
    //==========================================================================
    always_comb begin
        addr_next = prg_addr + 16'd1;
        hdr_byte  = 1'b0;
        if (no_load_addr_i) begin
            if (dl_addr_i == '0)
                addr_next = `PRG_DEFAULT_ADDR;
        end else if (dl_addr_i == 24'd0) begin
            addr_next = {prg_addr[15:8], dl_data_i};
            hdr_byte  = 1'b1;
        end else if (dl_addr_i == 24'd1) begin
            addr_next = {dl_data_i, prg_addr[7:0]};
            hdr_byte  = 1'b1;
        end else if (dl_addr_i == 24'd2) begin
            // First payload byte goes to the header address itself
            addr_next = prg_addr;
        end
    end

    // Pointer location for the current inject step
    always_comb begin
        case (inject_step[3:1])
            3'd0:    ptr_addr = `PTR_ADDR_0;
            3'd1:    ptr_addr = `PTR_ADDR_1;
            3'd2:    ptr_addr = `PTR_ADDR_2;
            3'd3:    ptr_addr = `PTR_ADDR_3;
            3'd4:    ptr_addr = `PTR_ADDR_4;
            3'd5:    ptr_addr = `PTR_ADDR_5;
            3'd6:    ptr_addr = `PTR_ADDR_6;
            default: ptr_addr = `PTR_ADDR_7;
        endcase
    end

    //==========================================================================
    // Write requests, inject sequence and auto reset
    //==========================================================================
    always_ff @(posedge clk_sys_i) begin
        if (reset_i) begin
            prg_dl_d      <= 1'b0;
            req_q         <= 1'b0;
            auto_reset    <= 1'b0;
            inject_step   <= '0;
            force_reset_o <= 1'b0;
        end else begin
            prg_dl_d      <= prg_dl;
            req_q         <= 1'b0;
            force_reset_o <= 1'b0;
            if (prg_dl && dl_wr_i) begin
                req_q <= !hdr_byte;
                if (!hdr_byte && addr_next == `PRG_DEFAULT_ADDR)
                    auto_reset <= 1'b1;
            end
            // Counter wraps back to idle after the last step
            if (prg_dl_d && !prg_dl)
                inject_step <= 5'd1;
            else if (inject_step != '0)
                inject_step <= inject_step + 5'd1;
            if (inject_wr)
                req_q <= 1'b1;
            if (inject_step == `INJECT_LAST) begin
                force_reset_o <= auto_reset;
                auto_reset    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (prg_dl && dl_wr_i) begin
            prg_addr <= addr_next;
            addr_q   <= addr_next;
            wdata_q  <= dl_data_i;
        end
        if (inject_wr) begin
            addr_q  <= ptr_addr;
            wdata_q <= inject_step[1] ? prg_addr[15:8] : prg_addr[7:0];
        end
    end

    assign bus.req   = req_q;
    assign bus.we    = 1'b1;
    assign bus.addr  = loader_pkg::mem_addr_t'(addr_q);
    assign bus.wdata = wdata_q;

    // A strobe during inject must not add a download write
    a_no_dl_during_inject: assert property (
        @(posedge clk_sys_i) disable iff (reset_i)
        (inject_step != '0 && dl_wr_i) |=> (!bus.req || $past(inject_wr)));

endmodule

// ==== design/tape_streamer.sv ====
//==========================================================================
// Tape streamer
// Stores TAP downloads from the tape base address and feeds the stored
// bytes to the cassette FIFO, one byte per CPU phase pair
//==========================================================================
`timescale 1ns/100ps
`include "loader_consts.svh"

module tape_streamer (
    input  logic                 clk_sys_i,
    input  logic                 reset_i,
    input  logic                 dl_active_i,
    input  logic                 dl_wr_i,
    input  loader_pkg::byte_t    dl_index_i,
    input  loader_pkg::dl_addr_t dl_addr_i,
    input  loader_pkg::byte_t    dl_data_i,
    input  logic                 p2_h_i,
    input  logic                 tap_full_i,
    output loader_pkg::byte_t    tap_byte_o,
    output logic                 tap_wrreq_o,
    output logic                 tap_version_o,
    output logic                 tap_restart_o,
    mem_bus_if.requester         bus
);

    loader_pkg::play_state_t state;
    loader_pkg::mem_addr_t   tap_addr;
    loader_pkg::mem_addr_t   tap_next;
    loader_pkg::mem_addr_t   tap_end;
    loader_pkg::mem_addr_t   play_addr;
    loader_pkg::mem_addr_t   addr_q;
    loader_pkg::byte_t       wdata_q;
    logic                    tap_dl;
    logic                    p2_d;
    logic                    p2_fall;
    logic                    p2_rise;
    logic                    play_go;
    logic                    req_q;
    logic                    we_q;
    logic                    rd_q;

    assign tap_dl   = dl_active_i && dl_index_i == `IDX_TAP;
    assign tap_next = (dl_addr_i == '0) ? `TAP_MEM_START : tap_addr + 1'b1;
    assign p2_fall  = p2_d && !p2_h_i;
    assign p2_rise  = !p2_d && p2_h_i;

    // Fetch only in a low phase, with data left and room in the FIFO
    assign play_go = state == loader_pkg::PLAY_IDLE && p2_fall && !dl_active_i &&
                     play_addr != tap_end && !tap_full_i;

    //==========================================================================
    // Download capture and playback FSM
    //==========================================================================
    always_ff @(posedge clk_sys_i) begin
        if (reset_i) begin
            state         <= loader_pkg::PLAY_IDLE;
            p2_d          <= 1'b0;
            req_q         <= 1'b0;
            rd_q          <= 1'b0;
            tap_wrreq_o   <= 1'b0;
            tap_version_o <= 1'b0;
            tap_restart_o <= 1'b1;
            play_addr     <= `TAP_MEM_START;
            tap_end       <= `TAP_MEM_START;
        end else begin
            p2_d          <= p2_h_i;
            req_q         <= 1'b0;
            rd_q          <= state == loader_pkg::PLAY_READ;
            tap_wrreq_o   <= 1'b0;
            tap_restart_o <= tap_dl;
            if (tap_dl) begin
                state     <= loader_pkg::PLAY_IDLE;
                play_addr <= `TAP_MEM_START;
                if (dl_wr_i) begin
                    req_q   <= 1'b1;
                    tap_end <= tap_next + 1'b1;
                    if (dl_addr_i == `TAP_VERSION_OFS)
                        tap_version_o <= dl_data_i[0];
                end
            end else begin
                case (state)
                    loader_pkg::PLAY_IDLE: begin
                        if (play_go) begin
                            req_q <= 1'b1;
                            state <= loader_pkg::PLAY_READ;
                        end
                    end
                    loader_pkg::PLAY_READ: state <= loader_pkg::PLAY_HOLD;
                    loader_pkg::PLAY_HOLD: begin
                        // Hand the byte over on the next high phase
                        if (p2_rise) begin
                            tap_wrreq_o <= 1'b1;
                            play_addr   <= play_addr + 1'b1;
                            state       <= loader_pkg::PLAY_IDLE;
                        end
                    end
                    default: state <= loader_pkg::PLAY_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (tap_dl && dl_wr_i) begin
            tap_addr <= tap_next;
            we_q     <= 1'b1;
            addr_q   <= tap_next;
            wdata_q  <= dl_data_i;
        end else if (play_go) begin
            we_q   <= 1'b0;
            addr_q <= play_addr;
        end
        if (rd_q)
            tap_byte_o <= bus.rdata;
    end

    assign bus.req   = req_q;
    assign bus.we    = we_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;

    a_wrreq_single: assert property (
        @(posedge clk_sys_i) disable iff (reset_i)
        tap_wrreq_o |=> !tap_wrreq_o);

endmodule

// ==== list.f ====
+incdir+design
design/loader_pkg.sv
design/mem_bus_if.sv
design/prg_loader.sv
design/tape_streamer.sv
design/mem_arbiter.sv
design/byte_ram.sv
design/loader_top.sv
tb/tb_loader.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the loader testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_loader -o sim_loader

./obj_dir/sim_loader | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== tb/loader_stim.txt ====
# type index mode count, then count download bytes
# ptr rst addr count, then count expected bytes (the tape stream for tap)
prg 01 0 8
01 10 a1 b2 c3 d4 e5 f6
1006 0 1001 6
a1 b2 c3 d4 e5 f6
prgnh 41 0 4
5a 6b 7c 8d
a003 1 a000 4
5a 6b 7c 8d
tap 81 0 16
43 36 34 2d 54 41 50 45 2d 52 41 57 01 9a 0c ff
0000 0 0000 16
43 36 34 2d 54 41 50 45 2d 52 41 57 01 9a 0c ff
tap 81 1 16
43 36 34 2d 54 41 50 45 2d 52 41 57 00 2f 31 42
0000 0 0000 16
43 36 34 2d 54 41 50 45 2d 52 41 57 00 2f 31 42

// ==== tb/tb_loader.sv ====
//==========================================================================
// Loader testbench
// Runs PRG and TAP downloads from the stimulus file, reads memory back
// through the CPU port and checks the tape stream into the FIFO
//==========================================================================
`timescale 1ns/100ps
`include "loader_consts.svh"

module tb_loader;

    localparam string STIM_FILE   = "tb/loader_stim.txt";
    localparam int    MAX_RECS    = 8;
    localparam int    MAX_BYTES   = 512;
    localparam int    MAX_GAP     = 5;
    localparam int    MAX_PAIR    = 12;
    localparam int    INJECT_WAIT = 40;

    logic        clk_sys        = 1'b0;
    logic        reset          = 1'b1;
    logic        dl_active_i    = 1'b0;
    logic        dl_wr_i        = 1'b0;
    logic        no_load_addr_i = 1'b0;
    logic [7:0]  dl_index_i     = 8'h00;
    logic [23:0] dl_addr_i      = 24'h0;
    logic [7:0]  dl_data_i      = 8'h00;
    logic        p2_h_i         = 1'b0;
    logic        tap_full_i     = 1'b0;
    logic        cpu_sel_i      = 1'b0;
    logic        cpu_we_i       = 1'b0;
    logic [15:0] cpu_addr_i     = 16'h0;
    logic [7:0]  cpu_data_i     = 8'h00;
    logic [7:0]  cpu_data_o;
    logic [7:0]  tap_byte_o;
    logic        tap_wrreq_o;
    logic        tap_version_o;
    logic        tap_restart_o;
    logic        force_reset_o;

    // Stimulus records
    int         num_recs = 0;
    int         dl_total = 0;
    int         exp_total = 0;
    bit         stim_ok = 1'b1;
    int         rec_type [0:MAX_RECS-1];
    int         rec_index [0:MAX_RECS-1];
    int         rec_mode [0:MAX_RECS-1];
    int         rec_dl_start [0:MAX_RECS-1];
    int         rec_dl_len [0:MAX_RECS-1];
    int         rec_ptr [0:MAX_RECS-1];
    int         rec_rst [0:MAX_RECS-1];
    int         rec_addr [0:MAX_RECS-1];
    int         rec_exp_start [0:MAX_RECS-1];
    int         rec_exp_len [0:MAX_RECS-1];
    logic [7:0] dl_bytes [0:MAX_BYTES-1];
    logic [7:0] exp_bytes [0:MAX_BYTES-1];

    // CPU operations handed to the phase generator
    bit          cpu_we_q [$];
    logic [15:0] cpu_addr_q [$];
    logic [7:0]  cpu_data_q [$];
    int          ops_issued = 0;
    int          ops_done = 0;

    logic [7:0]  stream_q [$];
    bit          full_random = 1'b0;
    bit          full_at_fall = 1'b0;
    int          rst_count = 0;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    loader_top uut (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .dl_active_i    (dl_active_i),
        .dl_wr_i        (dl_wr_i),
        .no_load_addr_i (no_load_addr_i),
        .dl_index_i     (dl_index_i),
        .dl_addr_i      (dl_addr_i),
        .dl_data_i      (dl_data_i),
        .p2_h_i         (p2_h_i),
        .tap_full_i     (tap_full_i),
        .cpu_sel_i      (cpu_sel_i),
        .cpu_we_i       (cpu_we_i),
        .cpu_addr_i     (cpu_addr_i),
        .cpu_data_i     (cpu_data_i),
        .cpu_data_o     (cpu_data_o),
        .tap_byte_o     (tap_byte_o),
        .tap_wrreq_o    (tap_wrreq_o),
        .tap_version_o  (tap_version_o),
        .tap_restart_o  (tap_restart_o),
        .force_reset_o  (force_reset_o)
    );

    initial begin
        forever #4 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles = cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // FIFO side and auto reset monitor
    always @(negedge clk_sys) begin
        if (!reset && tap_wrreq_o) begin
            stream_q.push_back(tap_byte_o);
            checks = checks + 1;
            assert (!full_at_fall) else begin
                errors = errors + 1;
                $display("tape byte was pushed after a low phase with the FIFO full");
            end
        end
        if (!reset && force_reset_o)
            rst_count = rst_count + 1;
    end

    task automatic check_value(input string name, input int got, input int exp);
        checks = checks + 1;
        assert (got == exp) else begin
            errors = errors + 1;
            $display("error %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic read_stimulus();
        int               fd;
        int               code;
        int               i;
        int               f0;
        int               f1;
        int               f2;
        int               f3;
        logic [63:0]      tag;
        logic [8*128-1:0] line;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            stim_ok = 1'b0;
        end else begin
            while (!$feof(fd) && stim_ok) begin
                code = $fscanf(fd, "%s", tag);
                if (code == 1 && tag == "#") begin
                    code = $fgets(line, fd);
                end else if (code == 1) begin
                    if (tag == "prg")
                        rec_type[num_recs] = 0;
                    else if (tag == "prgnh")
                        rec_type[num_recs] = 1;
                    else if (tag == "tap")
                        rec_type[num_recs] = 2;
                    else
                        stim_ok = 1'b0;
                    code = $fscanf(fd, "%h %d %d", f0, f1, f2);
                    rec_index[num_recs]    = f0;
                    rec_mode[num_recs]     = f1;
                    rec_dl_len[num_recs]   = f2;
                    rec_dl_start[num_recs] = dl_total;
                    for (i = 0; i < f2; i++) begin
                        code = $fscanf(fd, "%h", f0);
                        dl_bytes[dl_total] = f0[7:0];
                        dl_total = dl_total + 1;
                    end
                    code = $fscanf(fd, "%h %d %h %d", f0, f1, f2, f3);
                    if (code != 4)
                        stim_ok = 1'b0;
                    rec_ptr[num_recs]       = f0;
                    rec_rst[num_recs]       = f1;
                    rec_addr[num_recs]      = f2;
                    rec_exp_len[num_recs]   = f3;
                    rec_exp_start[num_recs] = exp_total;
                    for (i = 0; i < f3; i++) begin
                        code = $fscanf(fd, "%h", f0);
                        exp_bytes[exp_total] = f0[7:0];
                        exp_total = exp_total + 1;
                    end
                    num_recs = num_recs + 1;
                end
            end
            $fclose(fd);
            if (num_recs == 0)
                stim_ok = 1'b0;
        end
    endtask

    task automatic queue_cpu(input bit we, input logic [15:0] addr, input logic [7:0] data);
        cpu_we_q.push_back(we);
        cpu_addr_q.push_back(addr);
        cpu_data_q.push_back(data);
        ops_issued = ops_issued + 1;
    endtask

    task automatic wait_cpu_idle();
        while (ops_done != ops_issued)
            @(posedge clk_sys);
    endtask

    task automatic send_download(input int r);
        int i;
        int gap;
        @(posedge clk_sys);
        dl_index_i     <= rec_index[r][7:0];
        no_load_addr_i <= (rec_type[r] == 1);
        dl_active_i    <= 1'b1;
        for (i = 0; i < rec_dl_len[r]; i++) begin
            @(posedge clk_sys);
            dl_wr_i   <= 1'b1;
            dl_addr_i <= 24'(i);
            dl_data_i <= dl_bytes[rec_dl_start[r] + i];
            @(posedge clk_sys);
            dl_wr_i <= 1'b0;
            gap = 1 + $urandom % (MAX_GAP - 1);
            repeat (gap) @(posedge clk_sys);
        end
        if (rec_type[r] == 2) begin
            @(negedge clk_sys);
            check_value("tap_restart_o", tap_restart_o, 1);
            @(posedge clk_sys);
        end
        dl_active_i <= 1'b0;
    endtask

    //==========================================================================
    // PRG load, pointer patch and auto reset
    //==========================================================================
    task automatic run_prg(input int r);
        int          i;
        logic [15:0] ptr;
        ptr       = rec_ptr[r][15:0];
        rst_count = 0;
        send_download(r);
        // Inject sequence ends about 32 cycles after the download
        repeat (INJECT_WAIT) @(posedge clk_sys);
        check_value("force_reset_o pulses", rst_count, rec_rst[r]);
        for (i = 0; i < rec_exp_len[r]; i++)
            queue_cpu(1'b0, 16'(rec_addr[r] + i), exp_bytes[rec_exp_start[r] + i]);
        queue_cpu(1'b0, `PTR_ADDR_0, ptr[7:0]);
        queue_cpu(1'b0, `PTR_ADDR_1, ptr[15:8]);
        queue_cpu(1'b0, `PTR_ADDR_2, ptr[7:0]);
        queue_cpu(1'b0, `PTR_ADDR_3, ptr[15:8]);
        queue_cpu(1'b0, `PTR_ADDR_4, ptr[7:0]);
        queue_cpu(1'b0, `PTR_ADDR_5, ptr[15:8]);
        queue_cpu(1'b0, `PTR_ADDR_6, ptr[7:0]);
        queue_cpu(1'b0, `PTR_ADDR_7, ptr[15:8]);
        wait_cpu_idle();
    endtask

    //==========================================================================
    // TAP download and playback into the FIFO
    //==========================================================================
    task automatic run_tap(input int r);
        int         i;
        int         n;
        logic [7:0] wr_val [0:5];
        n = rec_exp_len[r];
        stream_q.delete();
        full_random = (rec_mode[r] != 0);
        send_download(r);
        @(negedge clk_sys);
        check_value("tap_version_o", tap_version_o,
                    dl_bytes[rec_dl_start[r] + `TAP_VERSION_OFS][0]);
        // CPU traffic in the high phase while the tape plays
        if (rec_mode[r] != 0) begin
            for (i = 0; i < 6; i++) begin
                wr_val[i] = $urandom % 256;
                queue_cpu(1'b1, 16'h0400 + 16'(i), wr_val[i]);
            end
            for (i = 0; i < 6; i++)
                queue_cpu(1'b0, 16'h0400 + 16'(i), wr_val[i]);
            wait_cpu_idle();
        end
        while (stream_q.size() < n)
            @(posedge clk_sys);
        repeat (4) @(posedge p2_h_i);
        full_random = 1'b0;
        check_value("tap_wrreq_o count", stream_q.size(), n);
        for (i = 0; i < n && i < stream_q.size(); i++)
            check_value("tap_byte_o", stream_q[i], exp_bytes[rec_exp_start[r] + i]);
    endtask

    // CPU clock phases, FIFO full level and CPU port accesses
    initial begin : phase_gen
        int          hi_len;
        int          lo_len;
        int          i;
        bit          op_valid;
        bit          op_we;
        logic [15:0] op_addr;
        logic [7:0]  op_data;
        wait (reset == 1'b0);
        @(posedge clk_sys);
        forever begin
            hi_len   = 3 + $urandom % 4;
            lo_len   = 3 + $urandom % 4;
            op_valid = cpu_addr_q.size() != 0;
            p2_h_i <= 1'b1;
            if (op_valid) begin
                op_we   = cpu_we_q.pop_front();
                op_addr = cpu_addr_q.pop_front();
                op_data = cpu_data_q.pop_front();
                cpu_sel_i  <= 1'b1;
                cpu_we_i   <= op_we;
                cpu_addr_i <= op_addr;
                cpu_data_i <= op_data;
            end
            @(posedge clk_sys);
            cpu_sel_i <= 1'b0;
            for (i = 1; i < hi_len; i++)
                @(posedge clk_sys);
            if (op_valid) begin
                if (!op_we)
                    check_value("cpu_data_o", cpu_data_o, op_data);
                ops_done = ops_done + 1;
            end
            full_at_fall = full_random && ($urandom % 2 == 1);
            p2_h_i     <= 1'b0;
            tap_full_i <= full_at_fall;
            repeat (lo_len) @(posedge clk_sys);
        end
    end

    initial begin : main
        int r;
        void'($urandom(32'h59258393));
        read_stimulus();
        if (!stim_ok) begin
            $display("the stimulus file could not be opened or read");
            $display(">>> FAIL");
            $finish;
        end else begin
            cycle_limit = 2 * (dl_total + exp_total) * (MAX_GAP + MAX_PAIR) + 1000;
            repeat (9) @(posedge clk_sys);
            @(negedge clk_sys);
            check_value("tap_restart_o", tap_restart_o, 1);
            check_value("tap_wrreq_o", tap_wrreq_o, 0);
            check_value("force_reset_o", force_reset_o, 0);
            @(posedge clk_sys);
            reset <= 1'b0;
            repeat (4) @(posedge clk_sys);
            for (r = 0; r < num_recs; r++) begin
                if (rec_type[r] == 2)
                    run_tap(r);
                else
                    run_prg(r);
            end
            $display("checks %0d, errors %0d", checks, errors);
            if (errors == 0)
                $display(">>> PASS");
            else
                $display(">>> FAIL");
            $finish;
        end
    end

endmodule
